/* compile.f */
+incdir+common
common/ex_pkg.sv
common/mul_if.sv
logic/ex_alu.sv
logic/store_align.sv
mult/shift_mul.sv
mult/mul_ctrl.sv
logic/ex_stage.sv
dv/ex_stage_chk.sv
dv/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module ex_stage_tb -o ex_stage_sim
status=0
./obj_dir/ex_stage_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "SIMULATION PASSED" sim.log; then
    exit 1
fi
exit 0

/* dv/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int            N_MUL       = 10;                // directed + random + reset case
    localparam int            CYCLE_LIMIT = 400 + 40 * N_MUL;
    localparam ex_pkg::word_t LINK_OFS    = 32'd8;             // return address skips delay slot

    logic                clk;
    logic                rst;
    logic                valid_i;
    ex_pkg::alu_op_e     alu_op_i;
    ex_pkg::src1_sel_e   src1_sel_i;
    ex_pkg::src2_sel_e   src2_sel_i;
    ex_pkg::word_t       pc_i;
    ex_pkg::word_t       inst_i;
    ex_pkg::word_t       rs_data_i;
    ex_pkg::word_t       rt_data_i;
    ex_pkg::store_size_e store_size_i;
    logic                load_i;
    logic                mul_i;
    logic                mul_signed_i;
    logic                rf_we_i;
    ex_pkg::reg_addr_t   rf_waddr_i;
    logic                ex_valid_o;
    ex_pkg::word_t       result_o;
    logic                rf_we_o;
    ex_pkg::reg_addr_t   rf_waddr_o;
    logic                mem_en_o;
    ex_pkg::byte_en_t    mem_wen_o;
    ex_pkg::word_t       mem_addr_o;
    ex_pkg::word_t       mem_wdata_o;
    logic                stall_o;
    logic                hilo_we_o;
    ex_pkg::word_t       hi_o;
    ex_pkg::word_t       lo_o;

    integer seed;
    int     val_errs = 0;   // wrong values and missing events
    int     chk_errs;       // timing assertion failures from the bound checker
    int     cyc      = 0;

    ex_stage i_ex_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ***********************************************************************
    // reference model and helpers
    // ***********************************************************************
    function automatic ex_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic ex_pkg::word_t alu_ref(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                              ex_pkg::word_t b);
        logic [4:0]    sh;
        ex_pkg::word_t r;
        sh = a[4:0];                                  // distance from source 1
        case (op)
            ex_pkg::ALU_ADD:  r = a + b;
            ex_pkg::ALU_SUB:  r = a + ~b + 32'd1;     // two's complement
            ex_pkg::ALU_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ex_pkg::ALU_SLTU: r = {31'b0, a < b};
            ex_pkg::ALU_AND:  r = a & b;
            ex_pkg::ALU_OR:   r = a | b;
            ex_pkg::ALU_XOR:  r = a ^ b;
            ex_pkg::ALU_NOR:  r = ~(a | b);
            ex_pkg::ALU_SLL:  r = b << sh;
            ex_pkg::ALU_SRL:  r = b >> sh;
            ex_pkg::ALU_SRA:  r = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ex_pkg::ALU_LUI:  r = {b[15:0], 16'h0};   // imm to upper half
            default:          r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            val_errs++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    // strobe valid for one edge and return 1 ns after the capture edge
    task automatic capture();
        valid_i = 1'b1;
        @(posedge clk);
        #1;
        valid_i = 1'b0;
    endtask

    // ***********************************************************************
    // test cases
    // ***********************************************************************
    task automatic alu_case(ex_pkg::alu_op_e op, ex_pkg::src1_sel_e s1, ex_pkg::src2_sel_e s2);
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        ex_pkg::word_t rnd;
        ex_pkg::word_t exp;
        rnd          = rand_word();
        alu_op_i     = op;
        src1_sel_i   = s1;
        src2_sel_i   = s2;
        pc_i         = rand_word();
        inst_i       = rand_word();
        rs_data_i    = rand_word();
        rt_data_i    = rand_word();
        store_size_i = ex_pkg::ST_NONE;
        load_i       = rnd[1];
        mul_i        = 1'b0;
        rf_we_i      = rnd[0];
        rf_waddr_i   = rnd[12:8];
        case (s1)
            ex_pkg::SRC1_PC: a = pc_i;
            ex_pkg::SRC1_SA: a = {27'b0, inst_i[10:6]};   // shamt field
            default:         a = rs_data_i;
        endcase
        case (s2)
            ex_pkg::SRC2_SIMM: b = {{16{inst_i[15]}}, inst_i[15:0]};
            ex_pkg::SRC2_ZIMM: b = {16'h0, inst_i[15:0]};
            ex_pkg::SRC2_LINK: b = LINK_OFS;
            default:           b = rt_data_i;
        endcase
        exp = alu_ref(op, a, b);
        capture();
        expect_eq("result_o", exp, result_o);
        expect_eq("rf_we_o", 32'(rf_we_i), 32'(rf_we_o));
        expect_eq("rf_waddr_o", 32'(rf_waddr_i), 32'(rf_waddr_o));
        expect_eq("ex_valid_o", 32'd1, 32'(ex_valid_o));
        expect_eq("mem_en_o", 32'(load_i), 32'(mem_en_o));   // loads only, no store
        expect_eq("mem_wen_o", 32'd0, 32'(mem_wen_o));
    endtask

    task automatic store_case(ex_pkg::store_size_e sz, logic [1:0] off);
        ex_pkg::word_t    base;
        ex_pkg::word_t    data;
        ex_pkg::byte_en_t wen_exp;
        ex_pkg::word_t    wd_exp;
        base         = rand_word() & 32'hffff_fffc;    // word aligned base
        data         = rand_word();
        alu_op_i     = ex_pkg::ALU_ADD;
        src1_sel_i   = ex_pkg::SRC1_REG;
        src2_sel_i   = ex_pkg::SRC2_SIMM;
        inst_i       = {16'h0, 14'h0, off};            // offset in the immediate
        rs_data_i    = base;
        rt_data_i    = data;
        store_size_i = sz;
        load_i       = 1'b0;
        mul_i        = 1'b0;
        rf_we_i      = 1'b0;
        wen_exp      = 4'b0000;
        wd_exp       = 32'h0;
        case (sz)
            ex_pkg::ST_BYTE: begin
                wen_exp = 4'b0001 << off;
                wd_exp  = {24'h0, data[7:0]} << (8 * off);
            end
            ex_pkg::ST_HALF: begin
                if (!off[0]) begin                     // odd offsets stay disabled
                    wen_exp = 4'b0011 << off;
                    wd_exp  = {16'h0, data[15:0]} << (8 * off);
                end
            end
            ex_pkg::ST_WORD: begin
                wen_exp = 4'b1111;
                wd_exp  = data;
            end
            default: ;
        endcase
        capture();
        expect_eq("mem_wen_o", 32'(wen_exp), 32'(mem_wen_o));
        if (wen_exp != 0) begin
            expect_eq("mem_wdata_o", wd_exp, mem_wdata_o);
        end
        expect_eq("mem_addr_o", base + {30'b0, off}, mem_addr_o);
        expect_eq("mem_en_o", 32'd1, 32'(mem_en_o));
    endtask

    task automatic mul_setup(ex_pkg::word_t a, ex_pkg::word_t b, logic sgn);
        alu_op_i     = ex_pkg::ALU_ADD;
        src1_sel_i   = ex_pkg::SRC1_REG;
        src2_sel_i   = ex_pkg::SRC2_REG;
        rs_data_i    = a;
        rt_data_i    = b;
        store_size_i = ex_pkg::ST_NONE;
        load_i       = 1'b0;
        mul_i        = 1'b1;
        mul_signed_i = sgn;
        rf_we_i      = 1'b0;
    endtask

    task automatic mul_case(ex_pkg::word_t a, ex_pkg::word_t b, logic sgn);
        ex_pkg::dword_t exp;
        ex_pkg::word_t  held;
        if (sgn) begin
            exp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        end else begin
            exp = {32'h0, a} * {32'h0, b};
        end
        mul_setup(a, b, sgn);
        capture();
        held      = result_o;
        mul_i     = 1'b0;                          // unrelated instruction offered
        rs_data_i = ~a;
        valid_i   = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        valid_i = 1'b0;                            // withdrawn long before the stall ends
        expect_eq("result_o", held, result_o);
        while (!hilo_we_o) begin
            @(posedge clk);
            #1;
        end
        expect_eq("hi_o", exp[63:32], hi_o);
        expect_eq("lo_o", exp[31:0], lo_o);
        @(posedge clk);
        #1;
    endtask

    task automatic reset_during_mul();
        mul_setup(rand_word(), rand_word(), 1'b1);
        capture();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;                                // cut the multiply short
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (40) begin
            @(posedge clk);
            #1;
            assert (!hilo_we_o && !stall_o) else begin
                val_errs++;
                $display("cancelled multiply still stalled or wrote hi/lo");
            end
        end
    endtask

    // ***********************************************************************
    // main sequence
    // ***********************************************************************
    initial begin
        ex_pkg::word_t rnd;
        seed         = 32'hd7c6;
        rst          = 1'b1;
        valid_i      = 1'b0;
        alu_op_i     = ex_pkg::ALU_ADD;
        src1_sel_i   = ex_pkg::SRC1_REG;
        src2_sel_i   = ex_pkg::SRC2_REG;
        pc_i         = 32'h0;
        inst_i       = 32'h0;
        rs_data_i    = 32'h0;
        rt_data_i    = 32'h0;
        store_size_i = ex_pkg::ST_NONE;
        load_i       = 1'b0;
        mul_i        = 1'b0;
        mul_signed_i = 1'b0;
        rf_we_i      = 1'b0;
        rf_waddr_i   = 5'd0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 12; i++) begin          // every op with four source mixes
            for (int j = 0; j < 4; j++) begin
                case (j)
                    0: alu_case(ex_pkg::alu_op_e'(i[3:0]), ex_pkg::SRC1_REG, ex_pkg::SRC2_REG);
                    1: alu_case(ex_pkg::alu_op_e'(i[3:0]), ex_pkg::SRC1_REG, ex_pkg::SRC2_SIMM);
                    2: alu_case(ex_pkg::alu_op_e'(i[3:0]), ex_pkg::SRC1_REG, ex_pkg::SRC2_ZIMM);
                    default: alu_case(ex_pkg::alu_op_e'(i[3:0]), ex_pkg::SRC1_SA,
                                      ex_pkg::SRC2_REG);
                endcase
            end
        end
        repeat (4) alu_case(ex_pkg::ALU_ADD, ex_pkg::SRC1_PC, ex_pkg::SRC2_LINK);   // pc + 8

        for (int s = 1; s < 4; s++) begin
            for (int off = 0; off < 4; off++) begin
                store_case(ex_pkg::store_size_e'(s[1:0]), off[1:0]);
            end
        end

        mul_case(32'hffff_fffb, 32'd7, 1'b1);           // -5 * 7
        mul_case(32'h8000_0000, 32'h8000_0000, 1'b1);   // most negative squared
        mul_case(32'hffff_ffff, 32'hffff_ffff, 1'b0);   // largest unsigned
        repeat (6) begin
            rnd = rand_word();
            mul_case(rand_word(), rand_word(), rnd[0]);
        end
        reset_during_mul();

        chk_errs = i_ex_stage.i_chk.fail_cnt;
        $display("errors: %0d value checks, %0d timing assertions", val_errs, chk_errs);
        if (val_errs == 0 && chk_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* dv/ex_stage_chk.sv */
`timescale 1ns/1ps

module ex_stage_chk (
    input logic             clk,
    input logic             rst,
    input logic             valid_i,
    input logic             mul_i,
    input logic             stall_o,
    input logic             hilo_we_o,
    input logic             ex_valid_o,
    input logic             mem_en_o,
    input logic             rf_we_o,
    input ex_pkg::byte_en_t mem_wen_o,
    input ex_pkg::word_t    result_o
);

    localparam logic [5:0] STALL_LEN = 6'd33;   // load edge + 32 iterations

    int         fail_cnt = 0;   // read by the testbench at the end
    logic [5:0] run_len;        // cycles of the current stall so far

    always_ff @(posedge clk) begin
        if (rst || !stall_o) begin
            run_len <= '0;
        end else begin
            run_len <= run_len + 1'b1;
        end
    end

    // ***********************************************************************
    // reset and stall timing
    // ***********************************************************************
    quiet_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !ex_valid_o && !stall_o && !hilo_we_o && !mem_en_o && !rf_we_o
                       && mem_wen_o == '0)
        else begin $error("outputs active during or right after reset"); fail_cnt++; end

    stall_on_capture: assert property (@(posedge clk) disable iff (rst)
        valid_i && mul_i && !stall_o |=> stall_o)
        else begin $error("stall_o missing in the multiply capture cycle"); fail_cnt++; end

    stall_not_long: assert property (@(posedge clk) disable iff (rst)
        stall_o |-> run_len < STALL_LEN)
        else begin $error("stall_o held longer than 33 cycles"); fail_cnt++; end

    stall_exact: assert property (@(posedge clk) disable iff (rst)
        $fell(stall_o) && !$past(rst) |-> run_len == STALL_LEN)
        else begin $error("stall_o ended early"); fail_cnt++; end

    hilo_after_stall: assert property (@(posedge clk) disable iff (rst)
        hilo_we_o |-> $fell(stall_o) && !$past(rst))
        else begin $error("hilo_we_o outside the cycle after the stall"); fail_cnt++; end

    hilo_present: assert property (@(posedge clk) disable iff (rst)
        $fell(stall_o) && !$past(rst) |-> hilo_we_o)
        else begin $error("stall ended without a hi/lo write"); fail_cnt++; end

    // the input register is frozen, so the alu output cannot move
    result_held: assert property (@(posedge clk) disable iff (rst)
        $past(stall_o) |-> $stable(result_o))
        else begin $error("result_o changed while the stage was held"); fail_cnt++; end

endmodule

bind ex_stage ex_stage_chk i_chk (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_i),
    .mul_i      (mul_i),
    .stall_o    (stall_o),
    .hilo_we_o  (hilo_we_o),
    .ex_valid_o (ex_valid_o),
    .mem_en_o   (mem_en_o),
    .rf_we_o    (rf_we_o),
    .mem_wen_o  (mem_wen_o),
    .result_o   (result_o)
);

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_i,
    input  ex_pkg::alu_op_e        alu_op_i,
    input  ex_pkg::src1_sel_e      src1_sel_i,
    input  ex_pkg::src2_sel_e      src2_sel_i,
    input  ex_pkg::word_t          pc_i,
    input  ex_pkg::word_t          inst_i,
    input  ex_pkg::word_t          rs_data_i,
    input  ex_pkg::word_t          rt_data_i,
    input  ex_pkg::store_size_e    store_size_i,
    input  logic                   load_i,
    input  logic                   mul_i,
    input  logic                   mul_signed_i,
    input  logic                   rf_we_i,
    input  ex_pkg::reg_addr_t      rf_waddr_i,
    output logic                   ex_valid_o,
    output ex_pkg::word_t          result_o,
    output logic                   rf_we_o,
    output ex_pkg::reg_addr_t      rf_waddr_o,
    output logic                   mem_en_o,
    output ex_pkg::byte_en_t       mem_wen_o,
    output ex_pkg::word_t          mem_addr_o,
    output ex_pkg::word_t          mem_wdata_o,
    output logic                   stall_o,
    output logic                   hilo_we_o,
    output ex_pkg::word_t          hi_o,
    output ex_pkg::word_t          lo_o
);

    // ***********************************************************************
    // id/ex register, frozen while the multiplier holds the stage
    // ***********************************************************************
    logic                valid_q;
    ex_pkg::alu_op_e     alu_op_q;
    ex_pkg::src1_sel_e   src1_sel_q;
    ex_pkg::src2_sel_e   src2_sel_q;
    ex_pkg::word_t       pc_q;
    ex_pkg::word_t       inst_q;
    ex_pkg::word_t       rs_data_q;
    ex_pkg::word_t       rt_data_q;
    ex_pkg::store_size_e store_size_q;
    logic                load_q;
    logic                mul_q;
    logic                mul_signed_q;
    logic                rf_we_q;
    ex_pkg::reg_addr_t   rf_waddr_q;

    ex_pkg::word_t       alu_result;  // also the memory address
    ex_pkg::byte_en_t    align_wen;   // ungated lane enables

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!stall_o) begin
            valid_q <= valid_i;          // bubble when nothing offered
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && !stall_o) begin    // payload only on a real capture
            alu_op_q     <= alu_op_i;
            src1_sel_q   <= src1_sel_i;
            src2_sel_q   <= src2_sel_i;
            pc_q         <= pc_i;
            inst_q       <= inst_i;
            rs_data_q    <= rs_data_i;
            rt_data_q    <= rt_data_i;
            store_size_q <= store_size_i;
            load_q       <= load_i;
            mul_q        <= mul_i;
            mul_signed_q <= mul_signed_i;
            rf_we_q      <= rf_we_i;
            rf_waddr_q   <= rf_waddr_i;
        end
    end

    ex_alu i_alu (
        .alu_op_i   (alu_op_q),
        .src1_sel_i (src1_sel_q),
        .src2_sel_i (src2_sel_q),
        .pc_i       (pc_q),
        .inst_i     (inst_q),
        .rs_data_i  (rs_data_q),
        .rt_data_i  (rt_data_q),
        .result_o   (alu_result)
    );

    store_align i_store (
        .store_size_i (store_size_q),
        .addr_lo_i    (alu_result[1:0]),   // byte offset in the word
        .rt_data_i    (rt_data_q),
        .wen_o        (align_wen),
        .wdata_o      (mem_wdata_o)
    );

    mul_if mul_bus ();

    mul_ctrl i_mul_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mul_valid_i  (valid_q & mul_q),
        .mul_signed_i (mul_signed_q),
        .rs_data_i    (rs_data_q),
        .rt_data_i    (rt_data_q),
        .mul          (mul_bus.master),
        .stall_o      (stall_o),
        .hilo_we_o    (hilo_we_o),
        .hi_o         (hi_o),
        .lo_o         (lo_o)
    );

    shift_mul i_shift_mul (
        .clk (clk),
        .rst (rst),
        .mul (mul_bus.slave)
    );

    // outputs, side effects qualified by the valid bit
    assign ex_valid_o = valid_q;
    assign result_o   = alu_result;
    assign rf_we_o    = valid_q & rf_we_q;
    assign rf_waddr_o = rf_waddr_q;
    assign mem_en_o   = valid_q & (load_q | (store_size_q != ex_pkg::ST_NONE));
    assign mem_wen_o  = valid_q ? align_wen : '0;
    assign mem_addr_o = alu_result;      // base + offset from the alu

endmodule

/* mult/mul_ctrl.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module mul_ctrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          mul_valid_i,
    input  logic          mul_signed_i,
    input  ex_pkg::word_t rs_data_i,
    input  ex_pkg::word_t rt_data_i,
    mul_if.master         mul,
    output logic          stall_o,
    output logic          hilo_we_o,
    output ex_pkg::word_t hi_o,
    output ex_pkg::word_t lo_o
);

    // ***********************************************************************
    // launch tracking
    // ***********************************************************************
    logic started_q;   // current mult/multu already sent to the unit

    always_ff @(posedge clk) begin
        if (rst) begin
            started_q <= 1'b0;
        end else if (mul.done) begin
            started_q <= 1'b0;      // ready for the next multiply
        end else if (mul.start) begin
            started_q <= 1'b1;
        end
    end

    // one start per captured multiply and never into a busy unit
    assign mul.start     = mul_valid_i & ~started_q & ~mul.busy;
    assign mul.is_signed = mul_signed_i;
    assign mul.op_a      = rs_data_i;
    assign mul.op_b      = rt_data_i;

    // ***********************************************************************
    // stall and hi/lo writeback
    // ***********************************************************************
    // stall from the capture cycle until the product shows up
    assign stall_o   = mul_valid_i & ~mul.done;

    // done drops stall and writes hi/lo in the same cycle
    assign hilo_we_o = mul_valid_i & mul.done;
    assign hi_o      = mul.product[2*`EX_WORD_W-1:`EX_WORD_W];   // upper word
    assign lo_o      = mul.product[`EX_WORD_W-1:0];              // lower word

endmodule

/* mult/shift_mul.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module shift_mul (
    input  logic clk,
    input  logic rst,
    mul_if.slave mul
);

    localparam int CNT_W = $clog2(`EX_MUL_CYCLES);
    localparam logic [CNT_W-1:0] LAST_IT = CNT_W'(`EX_MUL_CYCLES - 1);

    ex_pkg::mul_state_e state_q;
    logic [CNT_W-1:0]   cnt_q;      // iteration index

    ex_pkg::dword_t     mcand_q;    // multiplicand, moves left
    ex_pkg::word_t      mplier_q;   // multiplier, moves right
    ex_pkg::dword_t     acc_q;      // partial product
    logic               neg_q;      // result sign

    // ***********************************************************************
    // operand magnitudes
    // ***********************************************************************
    ex_pkg::word_t mag_a;
    ex_pkg::word_t mag_b;
    logic          a_neg;
    logic          b_neg;

    assign a_neg = mul.is_signed & mul.op_a[`EX_WORD_W-1];
    assign b_neg = mul.is_signed & mul.op_b[`EX_WORD_W-1];
    assign mag_a = a_neg ? -mul.op_a : mul.op_a;   // 0x80000000 stays as 2^31
    assign mag_b = b_neg ? -mul.op_b : mul.op_b;

    // ***********************************************************************
    // control fsm
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ex_pkg::MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ex_pkg::MUL_IDLE: begin
                    if (mul.start) begin
                        state_q <= ex_pkg::MUL_BUSY;   // load edge
                        cnt_q   <= '0;
                    end
                end
                ex_pkg::MUL_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LAST_IT) begin
                        state_q <= ex_pkg::MUL_DONE;   // after last add
                    end
                end
                default: state_q <= ex_pkg::MUL_IDLE;  // done lasts one cycle
            endcase
        end
    end

    // ***********************************************************************
    // datapath
    // ***********************************************************************
    always_ff @(posedge clk) begin
        if (state_q == ex_pkg::MUL_IDLE && mul.start) begin
            mcand_q  <= {{`EX_WORD_W{1'b0}}, mag_a};
            mplier_q <= mag_b;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
        end else if (state_q == ex_pkg::MUL_BUSY) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;     // add this bit's weight
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign mul.busy    = (state_q != ex_pkg::MUL_IDLE);
    assign mul.done    = (state_q == ex_pkg::MUL_DONE);
    assign mul.product = neg_q ? -acc_q : acc_q;   // sign fix on the magnitude

endmodule

/* logic/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  ex_pkg::store_size_e store_size_i,
    input  logic [1:0]          addr_lo_i,
    input  ex_pkg::word_t       rt_data_i,
    output ex_pkg::byte_en_t    wen_o,
    output ex_pkg::word_t       wdata_o
);

    logic [7:0]  st_byte;   // sb payload
    logic [15:0] st_half;   // sh payload

    assign st_byte = rt_data_i[7:0];
    assign st_half = rt_data_i[15:0];

    always_comb begin
        wen_o   = '0;        // no store, no lanes
        wdata_o = '0;
        case (store_size_i)
            ex_pkg::ST_BYTE: begin
                case (addr_lo_i)   // little endian lane pick
                    2'd0: begin
                        wen_o   = 4'b0001;
                        wdata_o = {24'b0, st_byte};
                    end
                    2'd1: begin
                        wen_o   = 4'b0010;
                        wdata_o = {16'b0, st_byte, 8'b0};
                    end
                    2'd2: begin
                        wen_o   = 4'b0100;
                        wdata_o = {8'b0, st_byte, 16'b0};
                    end
                    default: begin
                        wen_o   = 4'b1000;
                        wdata_o = {st_byte, 24'b0};
                    end
                endcase
            end
            ex_pkg::ST_HALF: begin
                if (addr_lo_i == 2'd0) begin
                    wen_o   = 4'b0011;           // low half
                    wdata_o = {16'b0, st_half};
                end else if (addr_lo_i == 2'd2) begin
                    wen_o   = 4'b1100;           // high half
                    wdata_o = {st_half, 16'b0};
                end
                // odd offsets drop the write
            end
            ex_pkg::ST_WORD: begin
                wen_o   = 4'b1111;
                wdata_o = rt_data_i;             // as is
            end
            default: ;
        endcase
    end

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
    input  ex_pkg::alu_op_e   alu_op_i,
    input  ex_pkg::src1_sel_e src1_sel_i,
    input  ex_pkg::src2_sel_e src2_sel_i,
    input  ex_pkg::word_t     pc_i,
    input  ex_pkg::word_t     inst_i,
    input  ex_pkg::word_t     rs_data_i,
    input  ex_pkg::word_t     rt_data_i,
    output ex_pkg::word_t     result_o
);

    localparam int HALF_W = `EX_WORD_W / 2;   // immediate field width
    localparam int SA_W   = 5;                // shamt / shift distance

    // ***********************************************************************
    // immediate and shamt extension
    // ***********************************************************************
    ex_pkg::word_t imm_sext;
    ex_pkg::word_t imm_zext;
    ex_pkg::word_t sa_zext;
    ex_pkg::word_t link_ofs;

    assign imm_sext = {{HALF_W{inst_i[HALF_W-1]}}, inst_i[HALF_W-1:0]};
    assign imm_zext = {{HALF_W{1'b0}}, inst_i[HALF_W-1:0]};
    assign sa_zext  = {{(`EX_WORD_W-SA_W){1'b0}}, inst_i[10:6]};   // shamt field
    assign link_ofs = `EX_WORD_W'(`EX_LINK_OFS);

    // ***********************************************************************
    // operand select
    // ***********************************************************************
    ex_pkg::word_t src1;
    ex_pkg::word_t src2;

    always_comb begin
        case (src1_sel_i)
            ex_pkg::SRC1_PC: src1 = pc_i;        // jal / bal link base
            ex_pkg::SRC1_SA: src1 = sa_zext;     // sll/srl/sra by constant
            default:         src1 = rs_data_i;
        endcase
    end

    always_comb begin
        case (src2_sel_i)
            ex_pkg::SRC2_SIMM: src2 = imm_sext;  // addi, loads, stores
            ex_pkg::SRC2_ZIMM: src2 = imm_zext;  // andi/ori/xori
            ex_pkg::SRC2_LINK: src2 = link_ofs;  // pc + 8
            default:           src2 = rt_data_i;
        endcase
    end

    // ***********************************************************************
    // alu
    // ***********************************************************************
    logic [SA_W-1:0] shamt;
    assign shamt = src1[SA_W-1:0];            // distance from src1, value from src2

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD:  result_o = src1 + src2;
            ex_pkg::ALU_SUB:  result_o = src1 - src2;
            ex_pkg::ALU_SLT:  result_o = ex_pkg::word_t'($signed(src1) < $signed(src2));
            ex_pkg::ALU_SLTU: result_o = ex_pkg::word_t'(src1 < src2);
            ex_pkg::ALU_AND:  result_o = src1 & src2;
            ex_pkg::ALU_OR:   result_o = src1 | src2;
            ex_pkg::ALU_XOR:  result_o = src1 ^ src2;
            ex_pkg::ALU_NOR:  result_o = ~(src1 | src2);
            ex_pkg::ALU_SLL:  result_o = src2 << shamt;
            ex_pkg::ALU_SRL:  result_o = src2 >> shamt;
            ex_pkg::ALU_SRA:  result_o = ex_pkg::word_t'($signed(src2) >>> shamt);
            ex_pkg::ALU_LUI:  result_o = {src2[HALF_W-1:0], {HALF_W{1'b0}}};
            default:          result_o = '0;
        endcase
    end

endmodule

/* common/mul_if.sv */
`timescale 1ns/1ps

interface mul_if;

    logic           start;      // one-cycle launch strobe
    logic           is_signed;  // mult vs multu
    ex_pkg::word_t  op_a;       // multiplicand
    ex_pkg::word_t  op_b;       // multiplier
    logic           busy;       // unit occupied, no start allowed
    logic           done;       // one-cycle, product valid
    ex_pkg::dword_t product;    // {hi, lo}

    // controller side
    modport master (
        output start, is_signed, op_a, op_b,
        input  busy, done, product
    );

    // multiplier side
    modport slave (
        input  start, is_signed, op_a, op_b,
        output busy, done, product
    );

endinterface

/* common/ex_pkg.sv */
`include "ex_cfg.svh"

package ex_pkg;

    // ***********************************************************************
    // data types
    // ***********************************************************************
    typedef logic [`EX_WORD_W-1:0]   word_t;      // one data word
    typedef logic [2*`EX_WORD_W-1:0] dword_t;     // full multiply product
    typedef logic [`EX_REG_AW-1:0]   reg_addr_t;  // gpr number
    typedef logic [`EX_WORD_W/8-1:0] byte_en_t;   // one bit per byte lane

    // ***********************************************************************
    // control encodings
    // ***********************************************************************
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,   // signed compare
        ALU_SLTU = 4'd3,   // unsigned compare
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11   // imm into upper half
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_REG = 2'd0,   // rs
        SRC1_PC  = 2'd1,   // link / pc-relative
        SRC1_SA  = 2'd2    // shamt field
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_REG  = 2'd0,  // rt
        SRC2_SIMM = 2'd1,  // sign-extended imm
        SRC2_ZIMM = 2'd2,  // zero-extended imm
        SRC2_LINK = 2'd3   // constant 8
    } src2_sel_e;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_BYTE = 2'd1,
        ST_HALF = 2'd2,
        ST_WORD = 2'd3
    } store_size_e;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_BUSY = 2'd1,   // iterating
        MUL_DONE = 2'd2    // product valid for one cycle
    } mul_state_e;

endpackage

/* common/ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// ***************************************************************************
// execute stage widths and constants
// ***************************************************************************

// data path and address width
`define EX_WORD_W 32

// register file write address
`define EX_REG_AW 5

// shift-add iterations, one per multiplier bit
`define EX_MUL_CYCLES 32

// return address = pc + this, skips the delay slot
`define EX_LINK_OFS 8

`endif
